//--- verilog/vseq_pkg.sv
/*
  Vector issue stage package
  Widths, functional unit and opcode encodings, the dispatcher request
  and the hazard vectors shared by the issue controller, the instruction
  tracker and the register scoreboard
*/

`default_nettype none

package vseq_pkg;

  ////////////////////////////////////////
  // Sizes
  ////////////////////////////////////////

  // Instructions that can be in flight at the same time
  localparam int NR_VINSN = 8;
  localparam int VID_W = $clog2(NR_VINSN);
  // Enough bits to count every in-flight instruction on one unit
  localparam int CNT_W = $clog2(NR_VINSN + 1);

  // Architectural vector register file
  localparam int NR_VREGS = 32;
  localparam int VREG_W = $clog2(NR_VREGS);

  // Functional units and how many running instructions each may hold
  localparam int NR_UNITS = 4;
  localparam int QUEUE_DEPTH = 2;

  typedef logic [VID_W-1:0] vid_t;
  typedef logic [NR_VINSN-1:0] vinsn_vec_t;
  typedef logic [VREG_W-1:0] vreg_t;

  ////////////////////////////////////////
  // Encodings
  ////////////////////////////////////////

  typedef enum logic [1:0] {
    UNIT_ALU   = 2'd0,
    UNIT_MUL   = 2'd1,
    UNIT_LOAD  = 2'd2,
    UNIT_STORE = 2'd3
  } unit_e;

  typedef enum logic [2:0] {
    OP_VADD  = 3'd0,
    OP_VSUB  = 3'd1,
    OP_VMUL  = 3'd2,
    OP_VMACC = 3'd3,
    OP_VLE   = 3'd4,
    OP_VSE   = 3'd5
  } op_e;

  // Instruction as it comes from the dispatcher
  typedef struct packed {
    op_e   op;
    vreg_t vs1;
    logic  use_vs1;
    vreg_t vs2;
    logic  use_vs2;
    vreg_t vd;
    logic  use_vd;
  } insn_req_t;

  // One bit per running instruction that the new one has to wait for
  typedef struct packed {
    vinsn_vec_t hazard_vs1;
    vinsn_vec_t hazard_vs2;
    vinsn_vec_t hazard_vd;
  } hazard_t;

  // Map an opcode onto the unit that executes it
  function automatic unit_e unit_of(op_e op);
    case (op)
      OP_VADD, OP_VSUB:  return UNIT_ALU;
      OP_VMUL, OP_VMACC: return UNIT_MUL;
      OP_VLE:            return UNIT_LOAD;
      OP_VSE:            return UNIT_STORE;
      // Unused encodings fall back on the ALU
      default:           return UNIT_ALU;
    endcase
  endfunction

endpackage

`default_nettype wire

//--- verilog/vseq_issue_if.sv
/*
  Issue event bundle
  One accepted instruction with its ID and target unit, sent from the
  issue controller to the instruction tracker and the register scoreboard
*/

`timescale 1ns/1ps
`default_nettype none

interface vseq_issue_if;

  // High for exactly the cycle in which the instruction is accepted
  logic issue;
  // ID handed out to the instruction
  vseq_pkg::vid_t vid;
  // Unit that will execute it
  vseq_pkg::unit_e unit;
  // Register operands of the instruction
  vseq_pkg::insn_req_t req;

  // The issue controller drives the event
  modport ctrl (
    output issue,
    output vid,
    output unit,
    output req
  );

  // Tracker and scoreboard record it at the next clock edge
  modport sink (
    input issue,
    input vid,
    input unit,
    input req
  );

endinterface

`default_nettype wire

//--- verilog/vseq_issue_ctrl.sv
/*
  Issue controller
  Decides whether the dispatcher request can be accepted, registers it
  with its ID and hazards as the unit request and holds that request
  while the units apply back-pressure
*/

`timescale 1ns/1ps
`default_nettype none

module vseq_issue_ctrl (
  input  wire logic                          clk_i,
  input  wire logic                          rst_ni,
  // Dispatcher side
  input  wire logic                          req_valid_i,
  input  vseq_pkg::insn_req_t                req_i,
  output logic                               req_ready_o,
  // State from the tracker and the scoreboard
  input  vseq_pkg::vid_t                     free_vid_i,
  input  wire logic                          full_i,
  input  wire logic [vseq_pkg::NR_UNITS-1:0] unit_ready_i,
  input  vseq_pkg::hazard_t                  hazard_i,
  // Request to the functional units
  output logic                               pe_req_valid_o,
  output vseq_pkg::insn_req_t                pe_req_o,
  output vseq_pkg::vid_t                     pe_req_vid_o,
  output vseq_pkg::unit_e                    pe_req_unit_o,
  output vseq_pkg::hazard_t                  pe_req_hazard_o,
  input  wire logic                          pe_req_ready_i,
  // Issue event towards the tracker and the scoreboard
  vseq_issue_if.ctrl                         issue_o
);

  ////////////////////////////////////////
  // Acceptance
  ////////////////////////////////////////

  vseq_pkg::unit_e unit_dec;
  logic held;
  logic load_stall;
  logic accept;

  // Target unit of the waiting instruction
  assign unit_dec = vseq_pkg::unit_of(req_i.op);

  // A request is held while the units have not taken it yet
  assign held = pe_req_valid_o && !pe_req_ready_i;

  // A load reads no vector register, so it cannot wait on operands
  // inside the unit and has to wait here until all its hazards are gone
  assign load_stall = (unit_dec == vseq_pkg::UNIT_LOAD) && (|hazard_i);

  // Ready needs a free ID, room on the target unit and no held request
  assign req_ready_o = !held && !full_i && unit_ready_i[unit_dec] && !load_stall;

  assign accept = req_valid_i && req_ready_o;

  // Announce the accepted instruction to the record keepers
  assign issue_o.issue = accept;
  assign issue_o.vid   = free_vid_i;
  assign issue_o.unit  = unit_dec;
  assign issue_o.req   = req_i;

  ////////////////////////////////////////
  // Unit request register
  ////////////////////////////////////////

  // Valid rises one cycle after acceptance and falls once consumed
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      pe_req_valid_o <= 1'b0;
    end else if (accept) begin
      pe_req_valid_o <= 1'b1;
    end else if (pe_req_ready_i) begin
      pe_req_valid_o <= 1'b0;
    end
  end

  // The payload only moves on acceptance, so it is frozen while held
  always_ff @(posedge clk_i) begin
    if (accept) begin
      pe_req_o        <= req_i;
      pe_req_vid_o    <= free_vid_i;
      pe_req_unit_o   <= unit_dec;
      pe_req_hazard_o <= hazard_i;
    end
  end

  ////////////////////////////////////////
  // Checks
  ////////////////////////////////////////

  // A request under back-pressure stays valid and unchanged in the next cycle
  property p_hold_stable;
    @(posedge clk_i) disable iff (!rst_ni)
      held |=> pe_req_valid_o && $stable(pe_req_o) && $stable(pe_req_vid_o) &&
               $stable(pe_req_unit_o) && $stable(pe_req_hazard_o);
  endproperty

  a_hold_stable : assert property (p_hold_stable)
    else $error("unit request changed while held under back-pressure");

endmodule

`default_nettype wire

//--- verilog/vinsn_tracker.sv
/*
  Running instruction tracker
  Keeps one running bitmap per unit, picks the lowest free ID and reports
  unit occupancy and the idle state
*/

`timescale 1ns/1ps
`default_nettype none

module vinsn_tracker (
  input  wire logic                                 clk_i,
  input  wire logic                                 rst_ni,
  vseq_issue_if.sink                                issue_i,
  input  wire logic [vseq_pkg::NR_UNITS-1:0]        done_valid_i,
  input  vseq_pkg::vid_t [vseq_pkg::NR_UNITS-1:0]   done_vid_i,
  output vseq_pkg::vid_t                            free_vid_o,
  output logic                                      full_o,
  output logic [vseq_pkg::NR_UNITS-1:0]             unit_ready_o,
  output vseq_pkg::vinsn_vec_t                      running_o,
  output logic                                      idle_o
);

  // Bit i of row u is set while instruction i runs on unit u
  vseq_pkg::vinsn_vec_t [vseq_pkg::NR_UNITS-1:0] running_d, running_q;

  // Number of set bits in one bitmap
  function automatic logic [vseq_pkg::CNT_W-1:0] popcount(vseq_pkg::vinsn_vec_t vec);
    logic [vseq_pkg::CNT_W-1:0] cnt;
    cnt = '0;
    for (int i = 0; i < vseq_pkg::NR_VINSN; i++) begin
      cnt = cnt + vseq_pkg::CNT_W'(vec[i]);
    end
    return cnt;
  endfunction

  // Done clears the named bit, issue sets the bit of the new ID
  always_comb begin
    running_d = running_q;
    for (int u = 0; u < vseq_pkg::NR_UNITS; u++) begin
      if (done_valid_i[u]) begin
        running_d[u][done_vid_i[u]] = 1'b0;
      end
      if (issue_i.issue && issue_i.unit == vseq_pkg::unit_e'(u)) begin
        running_d[u][issue_i.vid] = 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      running_q <= '0;
    end else begin
      running_q <= running_d;
    end
  end

  // Union over all units and the occupancy of each one
  always_comb begin
    running_o = '0;
    for (int u = 0; u < vseq_pkg::NR_UNITS; u++) begin
      running_o       = running_o | running_q[u];
      unit_ready_o[u] = popcount(running_q[u]) < vseq_pkg::CNT_W'(vseq_pkg::QUEUE_DEPTH);
    end
  end

  // Lowest ID not in use, scanned from the top so the lowest one wins
  always_comb begin
    free_vid_o = '0;
    for (int i = vseq_pkg::NR_VINSN - 1; i >= 0; i--) begin
      if (!running_o[i]) free_vid_o = vseq_pkg::vid_t'(i);
    end
  end

  assign full_o = &running_o;
  assign idle_o = ~|running_o;

  // The controller only hands out IDs that are free in this cycle
  a_issue_free : assert property (@(posedge clk_i) disable iff (!rst_ni)
    issue_i.issue |-> !running_o[issue_i.vid])
    else $error("issue targets a running ID");

  // A unit only reports completion of instructions it is running
  for (genvar u = 0; u < vseq_pkg::NR_UNITS; u++) begin : gen_done_chk
    a_done_running : assert property (@(posedge clk_i) disable iff (!rst_ni)
      done_valid_i[u] |-> running_q[u][done_vid_i[u]])
      else $error("done names an ID that is not running on unit %0d", u);
  end

endmodule

`default_nettype wire

//--- verilog/vreg_scoreboard.sv
/*
  Vector register scoreboard
  Tracks the last reader and writer of every vector register, computes
  the RAW, WAR and WAW vectors of the waiting instruction and keeps the
  global table of which running instruction depends on which
*/

`timescale 1ns/1ps
`default_nettype none

module vreg_scoreboard (
  input  wire logic                                       clk_i,
  input  wire logic                                       rst_ni,
  input  vseq_pkg::insn_req_t                             req_i,
  input  vseq_pkg::vinsn_vec_t                            running_i,
  vseq_issue_if.sink                                      issue_i,
  output vseq_pkg::hazard_t                               hazard_o,
  output vseq_pkg::vinsn_vec_t [vseq_pkg::NR_VINSN-1:0]   global_hazard_table_o
);

  // Last instruction that touched a register
  typedef struct packed {
    vseq_pkg::vid_t vid;
    logic           valid;
  } vreg_access_t;

  vreg_access_t [vseq_pkg::NR_VREGS-1:0] read_list_d, read_list_q;
  vreg_access_t [vseq_pkg::NR_VREGS-1:0] write_list_d, write_list_q;
  // Lists with finished instructions removed, before the new issue is added
  vreg_access_t [vseq_pkg::NR_VREGS-1:0] read_list_live, write_list_live;

  vseq_pkg::vinsn_vec_t [vseq_pkg::NR_VINSN-1:0] table_d, table_q;

  ////////////////////////////////////////
  // Access lists
  ////////////////////////////////////////

  always_comb begin
    read_list_live  = read_list_q;
    write_list_live = write_list_q;
    // An entry dies as soon as its instruction stops running
    for (int v = 0; v < vseq_pkg::NR_VREGS; v++) begin
      read_list_live[v].valid  = read_list_q[v].valid && running_i[read_list_q[v].vid];
      write_list_live[v].valid = write_list_q[v].valid && running_i[write_list_q[v].vid];
    end
  end

  always_comb begin
    read_list_d  = read_list_live;
    write_list_d = write_list_live;
    // The new instruction becomes the latest writer of vd and reader of its sources
    if (issue_i.issue) begin
      if (issue_i.req.use_vd) write_list_d[issue_i.req.vd] = '{vid: issue_i.vid, valid: 1'b1};
      if (issue_i.req.use_vs1) read_list_d[issue_i.req.vs1] = '{vid: issue_i.vid, valid: 1'b1};
      if (issue_i.req.use_vs2) read_list_d[issue_i.req.vs2] = '{vid: issue_i.vid, valid: 1'b1};
    end
  end

  ////////////////////////////////////////
  // Hazards of the waiting instruction
  ////////////////////////////////////////

  // Uses the pruned lists so that a finished producer no longer counts
  always_comb begin
    hazard_o = '0;
    // RAW on the sources
    if (req_i.use_vs1 && write_list_live[req_i.vs1].valid) begin
      hazard_o.hazard_vs1[write_list_live[req_i.vs1].vid] = 1'b1;
    end
    if (req_i.use_vs2 && write_list_live[req_i.vs2].valid) begin
      hazard_o.hazard_vs2[write_list_live[req_i.vs2].vid] = 1'b1;
    end
    if (req_i.use_vd) begin
      // WAR, the old reader must get its operand before vd is overwritten
      if (read_list_live[req_i.vd].valid) begin
        hazard_o.hazard_vs1[read_list_live[req_i.vd].vid] = 1'b1;
        hazard_o.hazard_vs2[read_list_live[req_i.vd].vid] = 1'b1;
        hazard_o.hazard_vd[read_list_live[req_i.vd].vid]  = 1'b1;
      end
      // WAW keeps the writes to vd in order
      if (write_list_live[req_i.vd].valid) begin
        hazard_o.hazard_vd[write_list_live[req_i.vd].vid] = 1'b1;
      end
    end
  end

  ////////////////////////////////////////
  // Global hazard table
  ////////////////////////////////////////

  always_comb begin
    // Drop the columns of instructions that have finished
    for (int r = 0; r < vseq_pkg::NR_VINSN; r++) begin
      table_d[r] = table_q[r] & running_i;
    end
    // Row of the new ID collects every instruction it waits for
    if (issue_i.issue) begin
      table_d[issue_i.vid] = hazard_o.hazard_vs1 | hazard_o.hazard_vs2 | hazard_o.hazard_vd;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      read_list_q  <= '0;
      write_list_q <= '0;
      table_q      <= '0;
    end else begin
      read_list_q  <= read_list_d;
      write_list_q <= write_list_d;
      table_q      <= table_d;
    end
  end

  // Finished producers vanish from the output in the cycle they stop running
  always_comb begin
    for (int r = 0; r < vseq_pkg::NR_VINSN; r++) begin
      global_hazard_table_o[r] = table_q[r] & running_i;
    end
  end

  // New IDs are free, so no instruction can end up waiting on itself
  for (genvar r = 0; r < vseq_pkg::NR_VINSN; r++) begin : gen_self_chk
    a_no_self_dep : assert property (@(posedge clk_i) disable iff (!rst_ni)
      !global_hazard_table_o[r][r])
      else $error("instruction %0d depends on itself", r);
  end

endmodule

`default_nettype wire

//--- verilog/vseq_top.sv
/*
  Vector issue stage top level
  Accepts one instruction per cycle from the dispatcher, gives it a free
  ID, computes its hazards and forwards it to one of four functional units
*/

`timescale 1ns/1ps
`default_nettype none

module vseq_top (
  input  wire logic                                         clk_i,
  input  wire logic                                         rst_ni,
  // Dispatcher side
  input  wire logic                                         req_valid_i,
  input  vseq_pkg::insn_req_t                               req_i,
  output logic                                              req_ready_o,
  // Functional unit side
  output logic                                              pe_req_valid_o,
  output vseq_pkg::insn_req_t                               pe_req_o,
  output vseq_pkg::vid_t                                    pe_req_vid_o,
  output vseq_pkg::unit_e                                   pe_req_unit_o,
  output vseq_pkg::hazard_t                                 pe_req_hazard_o,
  input  wire logic                                         pe_req_ready_i,
  input  wire logic [vseq_pkg::NR_UNITS-1:0]                done_valid_i,
  input  vseq_pkg::vid_t [vseq_pkg::NR_UNITS-1:0]           done_vid_i,
  // Status
  output vseq_pkg::vinsn_vec_t                              vinsn_running_o,
  output vseq_pkg::vinsn_vec_t [vseq_pkg::NR_VINSN-1:0]     global_hazard_table_o,
  output logic                                              idle_o
);

  // Tracker state seen by the issue controller
  vseq_pkg::vid_t free_vid;
  logic full;
  logic [vseq_pkg::NR_UNITS-1:0] unit_ready;

  // Hazards of the instruction waiting at the dispatcher port
  vseq_pkg::hazard_t hazard;

  // Accepted instruction, broadcast to both record keepers
  vseq_issue_if issue_if ();

  vseq_issue_ctrl issue_ctrl_i (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .req_valid_i     (req_valid_i),
    .req_i           (req_i),
    .req_ready_o     (req_ready_o),
    .free_vid_i      (free_vid),
    .full_i          (full),
    .unit_ready_i    (unit_ready),
    .hazard_i        (hazard),
    .pe_req_valid_o  (pe_req_valid_o),
    .pe_req_o        (pe_req_o),
    .pe_req_vid_o    (pe_req_vid_o),
    .pe_req_unit_o   (pe_req_unit_o),
    .pe_req_hazard_o (pe_req_hazard_o),
    .pe_req_ready_i  (pe_req_ready_i),
    .issue_o         (issue_if)
  );

  vinsn_tracker vinsn_tracker_i (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .issue_i      (issue_if),
    .done_valid_i (done_valid_i),
    .done_vid_i   (done_vid_i),
    .free_vid_o   (free_vid),
    .full_o       (full),
    .unit_ready_o (unit_ready),
    .running_o    (vinsn_running_o),
    .idle_o       (idle_o)
  );

  vreg_scoreboard vreg_scoreboard_i (
    .clk_i                 (clk_i),
    .rst_ni                (rst_ni),
    .req_i                 (req_i),
    .running_i             (vinsn_running_o),
    .issue_i               (issue_if),
    .hazard_o              (hazard),
    .global_hazard_table_o (global_hazard_table_o)
  );

endmodule

`default_nettype wire

//--- dv/vseq_tb_model.svh
/*
  Reference model of the issue stage
  Random source, opcode decode, free ID choice, unit occupancy, the
  expected RAW, WAR and WAW vectors and the per-edge state update
*/

`ifndef VSEQ_TB_MODEL_SVH
`define VSEQ_TB_MODEL_SVH

// Fibonacci LFSR with taps 32, 22, 2 and 1, one step per bit taken
function automatic logic [31:0] rand_bits(int n);
  logic [31:0] val;
  logic fb;
  val = '0;
  for (int i = 0; i < n; i++) begin
    fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
    lfsr_state = {lfsr_state[30:0], fb};
    val = {val[30:0], fb};
  end
  return val;
endfunction

// Add and subtract on the ALU, multiplies on the multiplier, memory ops on their own units
function automatic vseq_pkg::unit_e decode_unit(vseq_pkg::op_e op);
  if (op == vseq_pkg::OP_VMUL || op == vseq_pkg::OP_VMACC) return vseq_pkg::UNIT_MUL;
  if (op == vseq_pkg::OP_VLE) return vseq_pkg::UNIT_LOAD;
  if (op == vseq_pkg::OP_VSE) return vseq_pkg::UNIT_STORE;
  return vseq_pkg::UNIT_ALU;
endfunction

function automatic vseq_pkg::vinsn_vec_t running_union();
  vseq_pkg::vinsn_vec_t acc;
  acc = '0;
  for (int u = 0; u < vseq_pkg::NR_UNITS; u++) acc = acc | run_m[u];
  return acc;
endfunction

function automatic int unit_count(vseq_pkg::unit_e u);
  int cnt;
  cnt = 0;
  for (int i = 0; i < vseq_pkg::NR_VINSN; i++) cnt += run_m[u][i];
  return cnt;
endfunction

function automatic vseq_pkg::vid_t lowest_free_vid();
  vseq_pkg::vinsn_vec_t run;
  run = running_union();
  for (int i = 0; i < vseq_pkg::NR_VINSN; i++) begin
    if (!run[i]) return vseq_pkg::vid_t'(i);
  end
  return '0;
endfunction

// A list entry only counts while its instruction is still running
function automatic vseq_pkg::hazard_t exp_hazard(vseq_pkg::insn_req_t r);
  vseq_pkg::hazard_t h;
  vseq_pkg::vinsn_vec_t run;
  run = running_union();
  h = '0;
  if (r.use_vs1 && wl_valid[r.vs1] && run[wl_vid[r.vs1]]) h.hazard_vs1[wl_vid[r.vs1]] = 1'b1;
  if (r.use_vs2 && wl_valid[r.vs2] && run[wl_vid[r.vs2]]) h.hazard_vs2[wl_vid[r.vs2]] = 1'b1;
  if (r.use_vd && rl_valid[r.vd] && run[rl_vid[r.vd]]) begin
    h.hazard_vs1[rl_vid[r.vd]] = 1'b1;
    h.hazard_vs2[rl_vid[r.vd]] = 1'b1;
    h.hazard_vd[rl_vid[r.vd]]  = 1'b1;
  end
  if (r.use_vd && wl_valid[r.vd] && run[wl_vid[r.vd]]) h.hazard_vd[wl_vid[r.vd]] = 1'b1;
  return h;
endfunction

// State after one clock edge, given what was applied before it
function automatic void model_update(logic acc, vseq_pkg::vid_t vid, vseq_pkg::unit_e unit,
                                     vseq_pkg::insn_req_t r, vseq_pkg::hazard_t hz,
                                     logic [3:0] dv, vseq_pkg::vid_t [3:0] dvid);
  vseq_pkg::vinsn_vec_t run;
  run = running_union();
  for (int v = 0; v < vseq_pkg::NR_VREGS; v++) begin
    if (wl_valid[v] && !run[wl_vid[v]]) wl_valid[v] = 1'b0;
    if (rl_valid[v] && !run[rl_vid[v]]) rl_valid[v] = 1'b0;
  end
  // Columns of finished instructions leave the dependency table
  for (int i = 0; i < vseq_pkg::NR_VINSN; i++) begin
    tbl_m[i] = tbl_m[i] & run;
  end
  for (int u = 0; u < vseq_pkg::NR_UNITS; u++) begin
    if (dv[u]) run_m[u][dvid[u]] = 1'b0;
  end
  if (acc) begin
    if (r.use_vd) begin
      wl_vid[r.vd] = vid;
      wl_valid[r.vd] = 1'b1;
    end
    if (r.use_vs1) begin
      rl_vid[r.vs1] = vid;
      rl_valid[r.vs1] = 1'b1;
    end
    if (r.use_vs2) begin
      rl_vid[r.vs2] = vid;
      rl_valid[r.vs2] = 1'b1;
    end
    run_m[unit][vid] = 1'b1;
    // The new row lists every instruction the new one waits for
    tbl_m[vid] = hz.hazard_vs1 | hz.hazard_vs2 | hz.hazard_vd;
  end
endfunction

`endif

//--- dv/vseq_tb.sv
/*
  Testbench of the vector issue stage
  Drives random and directed instructions, mirrors the expected state
  in a model and compares every unit request, ready and status output
*/

`timescale 1ns/1ps
`default_nettype none

module vseq_tb;

  localparam int CLK_PERIOD = 100;
  localparam int RANDOM_CYCLES = 600;
  // Directed tests and drains need well under 400 cycles, with margin of four
  localparam int WATCHDOG_CYCLES = 4 * (RANDOM_CYCLES + 400);

  logic clk_i;
  logic rst_ni;
  logic req_valid_i;
  vseq_pkg::insn_req_t req_i;
  logic req_ready_o;
  logic pe_req_valid_o;
  vseq_pkg::insn_req_t pe_req_o;
  vseq_pkg::vid_t pe_req_vid_o;
  vseq_pkg::unit_e pe_req_unit_o;
  vseq_pkg::hazard_t pe_req_hazard_o;
  logic pe_req_ready_i;
  logic [vseq_pkg::NR_UNITS-1:0] done_valid_i;
  vseq_pkg::vid_t [vseq_pkg::NR_UNITS-1:0] done_vid_i;
  vseq_pkg::vinsn_vec_t vinsn_running_o;
  vseq_pkg::vinsn_vec_t [vseq_pkg::NR_VINSN-1:0] global_hazard_table_o;
  logic idle_o;

  ////////////////////////////////////////
  // Model state and bookkeeping
  ////////////////////////////////////////

  vseq_pkg::vinsn_vec_t run_m [vseq_pkg::NR_UNITS];
  vseq_pkg::vid_t wl_vid [vseq_pkg::NR_VREGS];
  logic wl_valid [vseq_pkg::NR_VREGS];
  vseq_pkg::vid_t rl_vid [vseq_pkg::NR_VREGS];
  logic rl_valid [vseq_pkg::NR_VREGS];
  // Dependency row of each ID as recorded when it was issued
  vseq_pkg::vinsn_vec_t tbl_m [vseq_pkg::NR_VINSN];
  logic [31:0] lfsr_state;
  // Unit request that the DUT should present
  logic exp_pe_valid;
  vseq_pkg::insn_req_t exp_req;
  vseq_pkg::vid_t exp_vid;
  vseq_pkg::unit_e exp_unit;
  vseq_pkg::hazard_t exp_hz;
  string test_name;
  int test_errs;
  int total_errs;
  int tests_run;
  int acc_count;

  `include "vseq_tb_model.svh"

  vseq_top vseq_top_i (.*);

  initial begin
    clk_i = 1'b0;
    forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk_i);
    $display("Watchdog expired after %0d cycles, the run did not finish", WATCHDOG_CYCLES);
    $display("Simulation FAILED");
    $finish;
  end

  task automatic check_val(string what, logic [63:0] exp, logic [63:0] act);
    if (exp !== act) begin
      $display("CHECK FAILED %s: %s expected %0h actual %0h", test_name, what, exp, act);
      test_errs++;
      total_errs++;
    end
  endtask

  // One clock edge: compare against the model, then advance the model
  task automatic cycle();
    vseq_pkg::unit_e u;
    vseq_pkg::hazard_t hz;
    vseq_pkg::vid_t fv;
    logic rdy;
    logic acc;
    @(posedge clk_i);
    u = decode_unit(req_i.op);
    hz = exp_hazard(req_i);
    fv = lowest_free_vid();
    rdy = !(exp_pe_valid && !pe_req_ready_i) && (running_union() != '1) &&
          (unit_count(u) < vseq_pkg::QUEUE_DEPTH) && !(u == vseq_pkg::UNIT_LOAD && |hz);
    check_val("req_ready_o", rdy, req_ready_o);
    check_val("pe_req_valid_o", exp_pe_valid, pe_req_valid_o);
    if (exp_pe_valid) begin
      check_val("pe_req_o", exp_req, pe_req_o);
      check_val("pe_req_vid_o", exp_vid, pe_req_vid_o);
      check_val("pe_req_unit_o", exp_unit, pe_req_unit_o);
      check_val("pe_req_hazard_o", exp_hz, pe_req_hazard_o);
    end
    check_val("vinsn_running_o", running_union(), vinsn_running_o);
    check_val("idle_o", running_union() == '0, idle_o);
    for (int r = 0; r < vseq_pkg::NR_VINSN; r++) begin
      check_val($sformatf("global_hazard_table_o[%0d]", r), tbl_m[r] & running_union(),
                global_hazard_table_o[r]);
    end
    acc = req_valid_i && req_ready_o;
    if (acc) begin
      exp_req = req_i;
      exp_vid = fv;
      exp_unit = u;
      exp_hz = hz;
      exp_pe_valid = 1'b1;
      acc_count++;
    end else if (pe_req_ready_i) begin
      exp_pe_valid = 1'b0;
    end
    model_update(acc, fv, u, req_i, hz, done_valid_i, done_vid_i);
  endtask

  // Some running ID of a unit, searched from a random start
  function automatic vseq_pkg::vid_t pick_running(int u, logic [2:0] start);
    logic [2:0] idx;
    for (int k = 0; k < vseq_pkg::NR_VINSN; k++) begin
      idx = start + 3'(k);
      if (run_m[u][idx]) return idx;
    end
    return '0;
  endfunction

  // Each unit with work completes one instruction with chance rate/4
  task automatic drive_done(int rate);
    logic fire;
    for (int u = 0; u < vseq_pkg::NR_UNITS; u++) begin
      fire = (rand_bits(2) < rate) && (run_m[u] != '0);
      done_valid_i[u] <= fire;
      done_vid_i[u] <= pick_running(u, 3'(rand_bits(3)));
    end
  endtask

  function automatic vseq_pkg::insn_req_t random_req();
    vseq_pkg::insn_req_t r;
    logic [2:0] o;
    o = 3'(rand_bits(3));
    if (o > 3'd5) o = o - 3'd2;
    r.op = vseq_pkg::op_e'(o);
    r.vs1 = vseq_pkg::vreg_t'(rand_bits(3));
    r.vs2 = vseq_pkg::vreg_t'(rand_bits(3));
    r.vd = vseq_pkg::vreg_t'(rand_bits(3));
    // Loads only write vd, stores only read their data register
    r.use_vs1 = r.op != vseq_pkg::OP_VLE;
    r.use_vs2 = r.op < vseq_pkg::OP_VLE;
    r.use_vd = r.op != vseq_pkg::OP_VSE;
    return r;
  endfunction

  function automatic vseq_pkg::insn_req_t make_req(vseq_pkg::op_e op, logic [4:0] vd,
                                                   logic use_vd);
    vseq_pkg::insn_req_t r;
    r = '0;
    r.op = op;
    r.vd = vd;
    r.use_vd = use_vd;
    return r;
  endfunction

  // Stop issuing and complete everything that runs
  task automatic drain();
    req_valid_i <= 1'b0;
    pe_req_ready_i <= 1'b1;
    for (int k = 0; k < 60 && (running_union() != '0 || exp_pe_valid); k++) begin
      drive_done(4);
      cycle();
    end
    done_valid_i <= '0;
    cycle();
    if (running_union() != '0) begin
      $display("Drain in %s did not complete all instructions", test_name);
      test_errs++;
      total_errs++;
    end
  endtask

  task automatic wait_accepts(int target, int limit);
    for (int k = 0; k < limit && acc_count < target; k++) cycle();
  endtask

  task automatic start_test(string name);
    test_name = name;
    test_errs = 0;
    acc_count = 0;
  endtask

  task automatic finish_test();
    tests_run++;
    $display("Test %s finished: %0d accepted, %0d errors", test_name, acc_count, test_errs);
  endtask

  initial begin
    lfsr_state = 32'h6261;
    rst_ni = 1'b0;
    req_valid_i = 1'b0;
    req_i = '0;
    pe_req_ready_i = 1'b0;
    done_valid_i = '0;
    done_vid_i = '0;
    exp_pe_valid = 1'b0;
    total_errs = 0;
    tests_run = 0;
    for (int u = 0; u < vseq_pkg::NR_UNITS; u++) run_m[u] = '0;
    for (int i = 0; i < vseq_pkg::NR_VINSN; i++) tbl_m[i] = '0;
    for (int v = 0; v < vseq_pkg::NR_VREGS; v++) begin
      wl_valid[v] = 1'b0;
      rl_valid[v] = 1'b0;
    end
    repeat (8) @(posedge clk_i);
    rst_ni <= 1'b1;

    start_test("random_traffic");
    for (int c = 0; c < RANDOM_CYCLES; c++) begin
      req_valid_i <= rand_bits(2) != 0;
      req_i <= random_req();
      pe_req_ready_i <= rand_bits(2) != 0;
      drive_done(1);
      cycle();
    end
    drain();
    finish_test();

    // Only QUEUE_DEPTH ALU instructions fit until one completes
    start_test("unit_full");
    req_i <= make_req(vseq_pkg::OP_VADD, 5'd0, 1'b0);
    req_valid_i <= 1'b1;
    repeat (6) cycle();
    check_val("accepted with full unit", vseq_pkg::QUEUE_DEPTH, acc_count);
    done_valid_i[vseq_pkg::UNIT_ALU] <= 1'b1;
    done_vid_i[vseq_pkg::UNIT_ALU] <= pick_running(vseq_pkg::UNIT_ALU, 3'd0);
    cycle();
    done_valid_i <= '0;
    wait_accepts(vseq_pkg::QUEUE_DEPTH + 1, 5);
    check_val("accepted after done", vseq_pkg::QUEUE_DEPTH + 1, acc_count);
    drain();
    finish_test();

    // The per-cycle checks verify the held payload and the low ready
    start_test("backpressure");
    pe_req_ready_i <= 1'b0;
    req_i <= make_req(vseq_pkg::OP_VADD, 5'd3, 1'b1);
    req_valid_i <= 1'b1;
    wait_accepts(1, 5);
    req_i <= make_req(vseq_pkg::OP_VSUB, 5'd4, 1'b1);
    repeat (10) cycle();
    check_val("accepted while held", 1, acc_count);
    drain();
    finish_test();

    // A load writing the same vd as a running multiply waits for it
    start_test("load_hazard");
    req_i <= make_req(vseq_pkg::OP_VMUL, 5'd5, 1'b1);
    req_valid_i <= 1'b1;
    wait_accepts(1, 5);
    req_i <= make_req(vseq_pkg::OP_VLE, 5'd5, 1'b1);
    repeat (8) cycle();
    check_val("load accepted with hazard", 1, acc_count);
    done_valid_i[vseq_pkg::UNIT_MUL] <= 1'b1;
    done_vid_i[vseq_pkg::UNIT_MUL] <= pick_running(vseq_pkg::UNIT_MUL, 3'd0);
    cycle();
    done_valid_i <= '0;
    wait_accepts(2, 5);
    check_val("load accepted after done", 2, acc_count);
    drain();
    finish_test();

    start_test("drain_idle");
    drain();
    check_val("idle_o", 1, idle_o);
    check_val("vinsn_running_o", 0, vinsn_running_o);
    check_val("global_hazard_table_o", 0, global_hazard_table_o);
    finish_test();

    $display("Tests run %0d, checks failed %0d", tests_run, total_errs);
    if (total_errs == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- project.f
+incdir+dv
verilog/vseq_pkg.sv
verilog/vseq_issue_if.sv
verilog/vseq_issue_ctrl.sv
verilog/vinsn_tracker.sv
verilog/vreg_scoreboard.sv
verilog/vseq_top.sv
dv/vseq_tb.sv

//--- Bender.yml
package:
  name: vseq

sources:
  - verilog/vseq_pkg.sv
  - verilog/vseq_issue_if.sv
  - verilog/vseq_issue_ctrl.sv
  - verilog/vinsn_tracker.sv
  - verilog/vreg_scoreboard.sv
  - verilog/vseq_top.sv
  - target: test
    include_dirs:
      - dv
    files:
      - dv/vseq_tb.sv
